// File: common/f2_defs.svh
`ifndef F2_DEFS_SVH
`define F2_DEFS_SVH

//////////////////////////////
// Bus widths
//////////////////////////////

// CPU data bus
`define F2_DATA_W 16

// Work RAM word address bits
`define F2_RAM_AW 15

// Input port register index bits
`define F2_IO_AW 4

//////////////////////////////
// Address map
//////////////////////////////

// Word address bits [22:15], byte address 0x100000
`define F2_RAM_BASE 8'h10

// Word address bits [22:4], byte address 0x300000
`define F2_IO_BASE 19'h18000

`endif

// File: common/f2_bus_pkg.sv
`default_nettype none

package f2_bus_pkg;

    // 68000 function code pins FC2..FC0
    typedef enum logic [2:0] {
        FC_USER_DATA  = 3'd1,
        FC_USER_PROG  = 3'd2,
        FC_SUPER_DATA = 3'd5,
        FC_SUPER_PROG = 3'd6,
        FC_INT_ACK    = 3'd7
    } cpu_fc_t;

    // Target of the current bus cycle
    typedef enum logic [1:0] {
        REGION_NONE     = 2'd0,
        REGION_WORK_RAM = 2'd1,
        REGION_IO       = 2'd2,
        REGION_IACK     = 2'd3
    } bus_region_t;

    typedef logic [15:0] cpu_word_t;

endpackage

`default_nettype wire

// File: common/f2_irq_pkg.sv
`default_nettype none

package f2_irq_pkg;

    // Priority level as seen on IPL2..IPL0, active high here
    typedef enum logic [2:0] {
        IRQ_NONE    = 3'd0,
        IRQ_VBLANK  = 3'd5,
        IRQ_OBJ_DMA = 3'd6
    } irq_level_t;

endpackage

`default_nettype wire

// File: hdl/bus_decoder.sv
`timescale 1ns/1ps
`default_nettype none

`include "f2_defs.svh"

module bus_decoder
    import f2_bus_pkg::*;
(
    input  wire             clk,
    input  wire             reset,

    input  wire      [22:0] cpu_addr,
    input  wire cpu_fc_t    cpu_fc,
    input  wire             cpu_as_n,
    input  wire       [1:0] cpu_ds_n,
    input  wire             cpu_rw,

    input  wire cpu_word_t  ram_q,
    input  wire cpu_word_t  io_q,

    output logic      [1:0] ram_we,
    output logic            io_sel,
    output logic            iack,
    output logic      [2:0] iack_level,

    output cpu_word_t       cpu_din,
    output logic            cpu_dtack_n,
    output logic            cpu_vpa_n
);

bus_region_t region;
logic        access;
logic        cycle_seen;

assign access = ~cpu_as_n;

// Acknowledge cycles override the address map
always_comb begin
    if (cpu_fc == FC_INT_ACK) begin
        region = REGION_IACK;
    end else if (cpu_addr[22:`F2_RAM_AW] == `F2_RAM_BASE) begin
        region = REGION_WORK_RAM;
    end else if (cpu_addr[22:`F2_IO_AW] == `F2_IO_BASE) begin
        region = REGION_IO;
    end else begin
        region = REGION_NONE;
    end
end

// Byte lanes written on every edge of the cycle
assign ram_we[1] = access & ~cpu_rw & (region == REGION_WORK_RAM) & ~cpu_ds_n[1];
assign ram_we[0] = access & ~cpu_rw & (region == REGION_WORK_RAM) & ~cpu_ds_n[0];
assign io_sel    = access & (region == REGION_IO);

//////////////////////////////
// Handshake
always_ff @(posedge clk) begin
    if (reset) begin
        cycle_seen  <= 1'b0;
        cpu_dtack_n <= 1'b1;
        cpu_vpa_n   <= 1'b1;
        iack        <= 1'b0;
    end else begin
        cycle_seen  <= access;
        cpu_dtack_n <= ~(access & (region != REGION_IACK));
        cpu_vpa_n   <= ~(access & (region == REGION_IACK));
        // Single pulse at the start of an acknowledge
        iack        <= access & ~cycle_seen & (region == REGION_IACK) & ~cpu_ds_n[0];
    end
end

// Level travels with the pulse
always_ff @(posedge clk) begin
    iack_level <= cpu_addr[2:0];
end

// Read data, unmapped reads as zero
always_comb begin
    case (region)
        REGION_WORK_RAM: cpu_din = ram_q;
        REGION_IO:       cpu_din = io_q;
        default:         cpu_din = {`F2_DATA_W{1'b0}};
    endcase
end

endmodule

`default_nettype wire

// File: hdl/work_ram.sv
`timescale 1ns/1ps
`default_nettype none

`include "f2_defs.svh"

module work_ram
    import f2_bus_pkg::*;
(
    input  wire                  clk,
    input  wire [`F2_RAM_AW-1:0] addr,
    input  wire            [1:0] we,
    input  wire cpu_word_t       data,
    output cpu_word_t            q
);

localparam int DEPTH  = 1 << `F2_RAM_AW;
localparam int LANE_W = `F2_DATA_W / 2;

logic [`F2_DATA_W-1:0] mem [0:DEPTH-1];

// we[1] is the upper byte, we[0] the lower
always_ff @(posedge clk) begin
    for (int lane = 0; lane < 2; lane++) begin
        if (we[lane]) begin
            mem[addr][lane*LANE_W +: LANE_W] <= data[lane*LANE_W +: LANE_W];
        end
    end
end

// Registered read, old data on a write cycle
always_ff @(posedge clk) begin
    q <= mem[addr];
end

endmodule

`default_nettype wire

// File: hdl/input_ports.sv
`timescale 1ns/1ps
`default_nettype none

`include "f2_defs.svh"

module input_ports
    import f2_bus_pkg::*;
(
    input  wire                 clk,
    input  wire                 sel,
    input  wire [`F2_IO_AW-1:0] index,

    input  wire           [7:0] joystick_p1,
    input  wire           [7:0] joystick_p2,
    input  wire           [1:0] start,
    input  wire           [1:0] coin,
    input  wire           [7:0] dswa,
    input  wire           [7:0] dswb,

    output cpu_word_t           q
);

logic [7:0] dswa_n;
logic [7:0] dswb_n;
logic [7:0] p1_n;
logic [7:0] p2_n;
logic [7:0] coin_n;

// Board order: start, buttons, then directions reversed
function automatic logic [7:0] player_byte(input logic start_bit, input logic [7:0] joy);
    return ~{start_bit, joy[6:4], joy[0], joy[1], joy[2], joy[3]};
endfunction

// Snapshot of the pins
always_ff @(posedge clk) begin
    dswa_n <= ~dswa;
    dswb_n <= ~dswb;
    p1_n   <= player_byte(start[0], joystick_p1);
    p2_n   <= player_byte(start[1], joystick_p2);
    coin_n <= ~{4'b0000, coin, 2'b00};
end

// Held between accesses
always_ff @(posedge clk) begin
    if (sel) begin
        case (index)
            4'd0:    q <= {8'h00, dswa_n};
            4'd1:    q <= {8'h00, dswb_n};
            4'd2:    q <= {8'h00, p1_n};
            4'd3:    q <= {8'h00, p2_n};
            4'd4:    q <= {8'h00, coin_n};
            default: q <= 16'h00FF;
        endcase
    end
end

endmodule

`default_nettype wire

// File: hdl/interrupt_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module interrupt_ctrl
    import f2_irq_pkg::*;
(
    input  wire        clk,
    input  wire        reset,

    input  wire        vblank,
    input  wire        obj_dma,

    input  wire        iack,
    input  wire  [2:0] iack_level,

    output irq_level_t ipl
);

logic vblank_prev;
logic obj_dma_prev;
logic vblank_rise;
logic obj_dma_fall;
logic req_vblank;
logic req_obj_dma;

always_ff @(posedge clk) begin
    vblank_prev  <= vblank;
    obj_dma_prev <= obj_dma;
end

assign vblank_rise  = vblank & ~vblank_prev;
assign obj_dma_fall = ~obj_dma & obj_dma_prev;

//////////////////////////////
// Pending requests
always_ff @(posedge clk) begin
    if (reset) begin
        req_vblank  <= 1'b0;
        req_obj_dma <= 1'b0;
    end else begin
        // A fresh edge beats a clear in the same cycle
        if (vblank_rise) begin
            req_vblank <= 1'b1;
        end else if (iack && iack_level == IRQ_VBLANK) begin
            req_vblank <= 1'b0;
        end

        if (obj_dma_fall) begin
            req_obj_dma <= 1'b1;
        end else if (iack && iack_level == IRQ_OBJ_DMA) begin
            req_obj_dma <= 1'b0;
        end
    end
end

// Object DMA outranks vblank
always_ff @(posedge clk) begin
    if (reset) begin
        ipl <= IRQ_NONE;
    end else if (req_obj_dma) begin
        ipl <= IRQ_OBJ_DMA;
    end else if (req_vblank) begin
        ipl <= IRQ_VBLANK;
    end else begin
        ipl <= IRQ_NONE;
    end
end

endmodule

`default_nettype wire

// File: hdl/f2_cpu_bus.sv
`timescale 1ns/1ps
`default_nettype none

`include "f2_defs.svh"

module f2_cpu_bus
    import f2_bus_pkg::*;
    import f2_irq_pkg::*;
(
    input  wire             clk,
    input  wire             reset,

    input  wire      [22:0] cpu_addr,
    input  wire cpu_fc_t    cpu_fc,
    input  wire             cpu_as_n,
    input  wire       [1:0] cpu_ds_n,
    input  wire             cpu_rw,
    input  wire cpu_word_t  cpu_dout,
    output cpu_word_t       cpu_din,
    output logic            cpu_dtack_n,
    output logic            cpu_vpa_n,
    output irq_level_t      cpu_ipl,

    input  wire       [7:0] joystick_p1,
    input  wire       [7:0] joystick_p2,
    input  wire       [1:0] start,
    input  wire       [1:0] coin,
    input  wire       [7:0] dswa,
    input  wire       [7:0] dswb,

    input  wire             vblank,
    input  wire             obj_dma
);

logic [1:0] ram_we;
cpu_word_t  ram_q;
logic       io_sel;
cpu_word_t  io_q;
logic       iack;
logic [2:0] iack_level;

//////////////////////////////
// Address decode
bus_decoder bus_decoder_i (
    .clk         (clk),
    .reset       (reset),
    .cpu_addr    (cpu_addr),
    .cpu_fc      (cpu_fc),
    .cpu_as_n    (cpu_as_n),
    .cpu_ds_n    (cpu_ds_n),
    .cpu_rw      (cpu_rw),
    .ram_q       (ram_q),
    .io_q        (io_q),
    .ram_we      (ram_we),
    .io_sel      (io_sel),
    .iack        (iack),
    .iack_level  (iack_level),
    .cpu_din     (cpu_din),
    .cpu_dtack_n (cpu_dtack_n),
    .cpu_vpa_n   (cpu_vpa_n)
);

//////////////////////////////
// Memory and ports
work_ram work_ram_i (
    .clk  (clk),
    .addr (cpu_addr[`F2_RAM_AW-1:0]),
    .we   (ram_we),
    .data (cpu_dout),
    .q    (ram_q)
);

input_ports input_ports_i (
    .clk         (clk),
    .sel         (io_sel),
    .index       (cpu_addr[`F2_IO_AW-1:0]),
    .joystick_p1 (joystick_p1),
    .joystick_p2 (joystick_p2),
    .start       (start),
    .coin        (coin),
    .dswa        (dswa),
    .dswb        (dswb),
    .q           (io_q)
);

//////////////////////////////
// Interrupts
interrupt_ctrl interrupt_ctrl_i (
    .clk        (clk),
    .reset      (reset),
    .vblank     (vblank),
    .obj_dma    (obj_dma),
    .iack       (iack),
    .iack_level (iack_level),
    .ipl        (cpu_ipl)
);

endmodule

`default_nettype wire

// File: bench/f2_bench_tasks.svh
`ifndef F2_BENCH_TASKS_SVH
`define F2_BENCH_TASKS_SVH

localparam int STROBE_LIMIT  = 16;
localparam int BUS_LATENCY   = 1;
localparam int RAM_WORDS     = 6;
localparam logic [22:0] UNMAPPED_ADDR = 23'h200000;

//////////////////////////////
// Stimulus helpers
//////////////////////////////

function automatic cpu_word_t random_word();
    int r;
    r = $random(seed);
    return r[15:0];
endfunction

function automatic logic [22:0] ram_addr(input logic [14:0] offset);
    return {`F2_RAM_BASE, offset};
endfunction

function automatic logic [22:0] io_addr(input logic [3:0] index);
    return {`F2_IO_BASE, index};
endfunction

// Start and buttons 6..4 and then directions 0..3 from high to low
// All bits active low
function automatic logic [7:0] expected_player(input logic start_bit, input logic [7:0] joy);
    logic [7:0] b;
    b[7]   = start_bit;
    b[6:4] = joy[6:4];
    b[3]   = joy[0];
    b[2]   = joy[1];
    b[1]   = joy[2];
    b[0]   = joy[3];
    return ~b;
endfunction

function automatic logic [7:0] expected_coins(input logic [1:0] coin_pins);
    logic [7:0] b;
    b      = 8'hFF;
    b[3:2] = ~coin_pins;
    return b;
endfunction

//////////////////////////////
// Compare tasks
//////////////////////////////

task automatic check_word(input string what, input cpu_word_t got, input cpu_word_t exp);
    check_count++;
    if (got !== exp) begin
        error_count++;
        $display("error at %0t: %s read %04h, expected %04h", $time, what, got, exp);
    end
endtask

task automatic check_level(input string what, input irq_level_t got, input irq_level_t exp);
    check_count++;
    if (got !== exp) begin
        error_count++;
        $display("error at %0t: %s is level %0d, expected %0d", $time, what, got, exp);
    end
endtask

task automatic check_flag(input string what, input logic got, input logic exp);
    check_count++;
    if (got !== exp) begin
        error_count++;
        $display("error at %0t: %s is %b, expected %b", $time, what, got, exp);
    end
endtask

task automatic check_latency(input string what, input int got);
    check_count++;
    if (got != BUS_LATENCY) begin
        error_count++;
        $display("error at %0t: %s strobe after %0d cycles, expected %0d",
                 $time, what, got, BUS_LATENCY);
    end
endtask

task automatic report_failure(input string msg);
    check_count++;
    error_count++;
    $display("%s (at %0t)", msg, $time);
endtask

task automatic finish_test(input string name, input int errors_before);
    if (error_count == errors_before) begin
        $display("test %s: ok", name);
    end else begin
        $display("test %s: %0d errors", name, error_count - errors_before);
    end
endtask

task automatic wait_cycles(input int n);
    repeat (n) @(posedge clk);
endtask

//////////////////////////////
// Bus cycles
//////////////////////////////

task automatic start_cycle(input logic [22:0] addr, input cpu_fc_t fc, input logic rw,
                           input logic [1:0] ds_n, input cpu_word_t data);
    @(posedge clk);
    cpu_addr <= addr;
    cpu_fc   <= fc;
    cpu_rw   <= rw;
    cpu_ds_n <= ds_n;
    cpu_dout <= data;
    cpu_as_n <= 1'b0;
endtask

task automatic end_cycle();
    @(posedge clk);
    cpu_as_n <= 1'b1;
    cpu_ds_n <= 2'b11;
    cpu_rw   <= 1'b1;
endtask

// Latency counts rising edges after as_n low
// It stays at -1 when no strobe came
task automatic wait_strobe(output int latency, output logic got_dtack, output logic got_vpa);
    int waited;
    waited    = 0;
    latency   = -1;
    got_dtack = 1'b0;
    got_vpa   = 1'b0;
    while (latency < 0 && waited < STROBE_LIMIT) begin
        @(negedge clk);
        if (!cpu_dtack_n || !cpu_vpa_n) begin
            latency   = waited;
            got_dtack = !cpu_dtack_n;
            got_vpa   = !cpu_vpa_n;
        end
        waited++;
    end
endtask

task automatic bus_write(input logic [22:0] addr, input logic [1:0] ds_n,
                         input cpu_word_t data, output int latency);
    logic got_dtack;
    logic got_vpa;
    start_cycle(addr, FC_SUPER_DATA, 1'b0, ds_n, data);
    wait_strobe(latency, got_dtack, got_vpa);
    if (latency < 0) begin
        report_failure($sformatf("write to %06h got no dtack_n within %0d cycles",
                                 addr, STROBE_LIMIT));
    end else if (!got_dtack || got_vpa) begin
        report_failure($sformatf("write to %06h was not answered with dtack_n alone", addr));
    end
    end_cycle();
endtask

task automatic bus_read(input logic [22:0] addr, output cpu_word_t data, output int latency);
    logic got_dtack;
    logic got_vpa;
    start_cycle(addr, FC_SUPER_DATA, 1'b1, 2'b00, '0);
    wait_strobe(latency, got_dtack, got_vpa);
    data = cpu_din;
    if (latency < 0) begin
        report_failure($sformatf("read from %06h got no dtack_n within %0d cycles",
                                 addr, STROBE_LIMIT));
    end else if (!got_dtack || got_vpa) begin
        report_failure($sformatf("read from %06h was not answered with dtack_n alone", addr));
    end
    end_cycle();
endtask

// Level goes on the low address bits with only the lower data strobe
task automatic bus_iack(input irq_level_t level, output int latency,
                        output logic got_dtack, output logic got_vpa);
    start_cycle({20'h00000, level}, FC_INT_ACK, 1'b1, 2'b10, '0);
    wait_strobe(latency, got_dtack, got_vpa);
    if (latency < 0) begin
        report_failure($sformatf("acknowledge of level %0d got no strobe within %0d cycles",
                                 level, STROBE_LIMIT));
    end
    end_cycle();
endtask

//////////////////////////////
// Directed tests
//////////////////////////////

task automatic test_reset_state();
    int errors_before;
    errors_before = error_count;
    @(negedge clk);
    check_flag("dtack_n after reset", cpu_dtack_n, 1'b1);
    check_flag("vpa_n after reset", cpu_vpa_n, 1'b1);
    check_level("ipl after reset", cpu_ipl, IRQ_NONE);
    finish_test("reset state", errors_before);
endtask

task automatic test_work_ram();
    cpu_word_t   wdata [RAM_WORDS];
    logic [14:0] offs [RAM_WORDS];
    cpu_word_t   rnd;
    cpu_word_t   got;
    cpu_word_t   low_data;
    int          lat;
    int          errors_before;
    errors_before = error_count;
    for (int i = 0; i < RAM_WORDS; i++) begin
        // Top bits from the index keep the addresses apart
        rnd      = random_word();
        offs[i]  = {3'(i), rnd[11:0]};
        wdata[i] = random_word();
        bus_write(ram_addr(offs[i]), 2'b00, wdata[i], lat);
        check_latency("work RAM write", lat);
    end
    for (int i = 0; i < RAM_WORDS; i++) begin
        bus_read(ram_addr(offs[i]), got, lat);
        check_latency("work RAM read", lat);
        check_word($sformatf("work RAM word %04h", offs[i]), got, wdata[i]);
    end
    low_data = random_word();
    bus_write(ram_addr(offs[0]), 2'b10, low_data, lat);
    bus_read(ram_addr(offs[0]), got, lat);
    check_word("work RAM after lower byte write", got, {wdata[0][15:8], low_data[7:0]});
    finish_test("work RAM", errors_before);
endtask

task automatic test_input_ports();
    cpu_word_t rnd_a;
    cpu_word_t rnd_b;
    cpu_word_t rnd_c;
    cpu_word_t got;
    int        lat;
    int        errors_before;
    errors_before = error_count;
    rnd_a = random_word();
    rnd_b = random_word();
    rnd_c = random_word();
    @(posedge clk);
    joystick_p1 <= rnd_a[7:0];
    joystick_p2 <= rnd_a[15:8];
    dswa        <= rnd_b[7:0];
    dswb        <= rnd_b[15:8];
    start       <= rnd_c[1:0];
    coin        <= rnd_c[3:2];
    // Snapshot picks up the new pins
    wait_cycles(1);
    bus_read(io_addr(4'd0), got, lat);
    check_latency("input port read", lat);
    check_word("dswa port", got, {8'h00, ~rnd_b[7:0]});
    bus_read(io_addr(4'd1), got, lat);
    check_word("dswb port", got, {8'h00, ~rnd_b[15:8]});
    bus_read(io_addr(4'd2), got, lat);
    check_word("player 1 port", got, {8'h00, expected_player(rnd_c[0], rnd_a[7:0])});
    bus_read(io_addr(4'd3), got, lat);
    check_word("player 2 port", got, {8'h00, expected_player(rnd_c[1], rnd_a[15:8])});
    bus_read(io_addr(4'd4), got, lat);
    check_word("coin port", got, {8'h00, expected_coins(rnd_c[3:2])});
    bus_read(io_addr(4'd7), got, lat);
    check_word("unused port 7", got, 16'h00FF);
    finish_test("input ports", errors_before);
endtask

task automatic test_unmapped();
    cpu_word_t got;
    int        lat;
    int        errors_before;
    errors_before = error_count;
    bus_read(UNMAPPED_ADDR, got, lat);
    check_latency("unmapped read", lat);
    check_word("unmapped read", got, 16'h0000);
    finish_test("unmapped access", errors_before);
endtask

task automatic test_vblank_irq();
    int   lat;
    logic got_dtack;
    logic got_vpa;
    int   errors_before;
    errors_before = error_count;
    @(posedge clk);
    vblank <= 1'b1;
    // Edge sampled, request set, level registered
    wait_cycles(2);
    @(negedge clk);
    check_level("ipl after vblank rise", cpu_ipl, IRQ_VBLANK);
    bus_iack(IRQ_VBLANK, lat, got_dtack, got_vpa);
    check_latency("vblank acknowledge", lat);
    check_flag("vpa_n in acknowledge", got_vpa, 1'b1);
    check_flag("dtack_n in acknowledge", got_dtack, 1'b0);
    wait_cycles(1);
    @(negedge clk);
    check_level("ipl after vblank acknowledge", cpu_ipl, IRQ_NONE);
    @(posedge clk);
    vblank <= 1'b0;
    wait_cycles(2);
    finish_test("vblank interrupt", errors_before);
endtask

task automatic test_irq_priority();
    int   lat;
    logic got_dtack;
    logic got_vpa;
    int   errors_before;
    errors_before = error_count;
    @(posedge clk);
    vblank  <= 1'b1;
    obj_dma <= 1'b0;
    wait_cycles(2);
    @(negedge clk);
    check_level("ipl with both requests", cpu_ipl, IRQ_OBJ_DMA);
    bus_iack(IRQ_OBJ_DMA, lat, got_dtack, got_vpa);
    check_latency("object DMA acknowledge", lat);
    check_flag("vpa_n in object DMA acknowledge", got_vpa, 1'b1);
    check_flag("dtack_n in object DMA acknowledge", got_dtack, 1'b0);
    wait_cycles(1);
    @(negedge clk);
    check_level("ipl after object DMA acknowledge", cpu_ipl, IRQ_VBLANK);
    bus_iack(IRQ_VBLANK, lat, got_dtack, got_vpa);
    check_latency("second vblank acknowledge", lat);
    check_flag("vpa_n in vblank acknowledge", got_vpa, 1'b1);
    check_flag("dtack_n in vblank acknowledge", got_dtack, 1'b0);
    wait_cycles(1);
    @(negedge clk);
    check_level("ipl after both acknowledged", cpu_ipl, IRQ_NONE);
    @(posedge clk);
    vblank  <= 1'b0;
    obj_dma <= 1'b1;
    finish_test("interrupt priority", errors_before);
endtask

`endif

// File: bench/tb_f2_cpu_bus.sv
`timescale 1ns/1ps
`default_nettype none

`include "f2_defs.svh"

module tb_f2_cpu_bus
    import f2_bus_pkg::*;
    import f2_irq_pkg::*;
();

localparam int CLK_PERIOD   = 40;
localparam int RESET_CYCLES = 4;

// Directed sequence is a few hundred cycles, limit leaves wide margin
localparam int TIMEOUT_CYCLES = 3000;

logic        clk;
logic        reset;

logic [22:0] cpu_addr;
cpu_fc_t     cpu_fc;
logic        cpu_as_n;
logic  [1:0] cpu_ds_n;
logic        cpu_rw;
cpu_word_t   cpu_dout;
cpu_word_t   cpu_din;
logic        cpu_dtack_n;
logic        cpu_vpa_n;
irq_level_t  cpu_ipl;

logic  [7:0] joystick_p1;
logic  [7:0] joystick_p2;
logic  [1:0] start;
logic  [1:0] coin;
logic  [7:0] dswa;
logic  [7:0] dswb;
logic        vblank;
logic        obj_dma;

integer      seed;
int          check_count = 0;
int          error_count = 0;
int          cycle_count = 0;

`include "f2_bench_tasks.svh"

f2_cpu_bus f2_cpu_bus_i (
    .clk         (clk),
    .reset       (reset),
    .cpu_addr    (cpu_addr),
    .cpu_fc      (cpu_fc),
    .cpu_as_n    (cpu_as_n),
    .cpu_ds_n    (cpu_ds_n),
    .cpu_rw      (cpu_rw),
    .cpu_dout    (cpu_dout),
    .cpu_din     (cpu_din),
    .cpu_dtack_n (cpu_dtack_n),
    .cpu_vpa_n   (cpu_vpa_n),
    .cpu_ipl     (cpu_ipl),
    .joystick_p1 (joystick_p1),
    .joystick_p2 (joystick_p2),
    .start       (start),
    .coin        (coin),
    .dswa        (dswa),
    .dswb        (dswb),
    .vblank      (vblank),
    .obj_dma     (obj_dma)
);

//////////////////////////////
// Clock and timeout
//////////////////////////////

initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
end

initial begin
    while (cycle_count < TIMEOUT_CYCLES) begin
        @(posedge clk);
        cycle_count++;
    end
    $display("timeout: run stopped after %0d cycles without finishing", TIMEOUT_CYCLES);
    $display("STATUS: FAIL");
    $finish;
end

//////////////////////////////
// Test sequence
//////////////////////////////

initial begin
    seed = 32'hd2b2_ed73;

    // Bus idle, obj_dma idle high so no falling edge at start
    reset       <= 1'b1;
    cpu_addr    <= '0;
    cpu_fc      <= FC_SUPER_DATA;
    cpu_as_n    <= 1'b1;
    cpu_ds_n    <= 2'b11;
    cpu_rw      <= 1'b1;
    cpu_dout    <= '0;
    joystick_p1 <= '0;
    joystick_p2 <= '0;
    start       <= '0;
    coin        <= '0;
    dswa        <= '0;
    dswb        <= '0;
    vblank      <= 1'b0;
    obj_dma     <= 1'b1;

    repeat (RESET_CYCLES) @(posedge clk);
    reset <= 1'b0;

    test_reset_state();
    test_work_ram();
    test_input_ports();
    test_unmapped();
    test_vblank_irq();
    test_irq_priority();

    $display("checks passed %0d, failed %0d", check_count - error_count, error_count);
    if (error_count == 0) begin
        $display("STATUS: PASS");
    end else begin
        $display("STATUS: FAIL");
    end
    $finish;
end

endmodule

`default_nettype wire

// File: verilog.f
+incdir+common
+incdir+bench
common/f2_bus_pkg.sv
common/f2_irq_pkg.sv
hdl/bus_decoder.sv
hdl/work_ram.sv
hdl/input_ports.sv
hdl/interrupt_ctrl.sv
hdl/f2_cpu_bus.sv
bench/tb_f2_cpu_bus.sv

// File: run_sim.sh
#!/bin/sh
# Build the testbench with Verilator and run it
set -e

cd "$(dirname "$0")"

verilator --binary --timing \
    -f verilog.f \
    --top-module tb_f2_cpu_bus \
    --Mdir obj_dir \
    -o tb_f2_cpu_bus

./obj_dir/tb_f2_cpu_bus > sim.log 2>&1 || true
cat sim.log

if grep -q "STATUS: FAIL" sim.log; then
    echo "simulation reported failure"
    exit 1
fi
if ! grep -q "STATUS: PASS" sim.log; then
    echo "simulation ended without a result"
    exit 1
fi
echo "simulation passed"
